// File: dcache_cfg.svh
// fixed cache geometry; the package widths derive from these, so change them together
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// --------------------------------------------------
// geometry
// --------------------------------------------------

`define DC_SETS      4   // sets, index from word address bits [3:2]
`define DC_WAYS      2   // ways per set, victim logic assumes two
`define DC_WORDS     4   // words per line

// --------------------------------------------------
// widths
// --------------------------------------------------

`define DC_WORD_BITS 32  // processor data word
`define DC_ADDR_BITS 30  // processor word address

`endif

// File: dcache_pkg.sv
// shared types for the data cache; widths follow the geometry header and must not be edited here
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------

	typedef logic [`DC_WORD_BITS-1:0]                        word_t;
	typedef logic [`DC_ADDR_BITS-1:0]                        word_addr_t;
	typedef logic [`DC_ADDR_BITS-$clog2(`DC_WORDS)-1:0]      line_addr_t; // 28 bits
	typedef logic [`DC_WORDS*`DC_WORD_BITS-1:0]              line_t;
	typedef logic [$clog2(`DC_SETS)-1:0]                     set_idx_t;
	typedef logic [$clog2(`DC_WORDS)-1:0]                    word_sel_t;
	typedef logic [`DC_ADDR_BITS-$clog2(`DC_WORDS)-$clog2(`DC_SETS)-1:0] tag_t;

	// --------------------------------------------------
	// request bundles
	// --------------------------------------------------

	typedef struct packed {
		logic       read;
		logic       write;
		word_addr_t addr;
		word_t      wdata;
	} proc_req_t; // 64 bits

	typedef struct packed {
		logic       read;
		logic       write;
		line_addr_t addr;
		line_t      wdata;
	} mem_req_t; // 158 bits

	// miss handling FSM
	typedef enum logic [1:0] {
		COMPARE    = 2'd0,
		WRITE_BACK = 2'd1,
		ALLOCATE   = 2'd2
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: dcache_store.sv
// two-way arrays with one victim bit per set; a hit write lands at the same edge it is accepted
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_store
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      proc_reset,
	input  proc_req_t proc_req,
	input  logic      fill_en,
	input  line_t     fill_line,
	input  logic      clean_en,
	output logic      hit,
	output logic      hit_way,
	output word_t     rdata,
	output logic      victim_way,
	output logic      victim_dirty,
	output line_t     victim_line,
	output tag_t      victim_tag
);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------

	logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
	logic [`DC_SETS-1:0] dirty_q [`DC_WAYS];
	logic [`DC_SETS-1:0] victim_q;            // way the next fill replaces
	tag_t                tag_q   [`DC_WAYS][`DC_SETS];
	line_t               data_q  [`DC_WAYS][`DC_SETS];

	set_idx_t            set;
	word_sel_t           sel;
	tag_t                req_tag;
	logic [`DC_WAYS-1:0] way_hit;
	logic                wr_hit;

	// address split into tag | set | word
	assign sel     = proc_req.addr[$bits(word_sel_t)-1:0];
	assign set     = proc_req.addr[$bits(word_sel_t) +: $bits(set_idx_t)];
	assign req_tag = proc_req.addr[$bits(word_addr_t)-1 -: $bits(tag_t)];

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------

	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			way_hit[w] = valid_q[w][set] && (tag_q[w][set] == req_tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];  // way 1 or else way 0
	assign rdata   = data_q[hit_way][set][sel*`DC_WORD_BITS +: `DC_WORD_BITS];
	assign wr_hit  = proc_req.write && hit;

	assign victim_way   = victim_q[set];
	assign victim_dirty = dirty_q[victim_way][set];  // dirty implies valid
	assign victim_line  = data_q[victim_way][set];
	assign victim_tag   = tag_q[victim_way][set];

	// --------------------------------------------------
	// line state
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			victim_q <= '0;
		end else if (fill_en) begin
			valid_q[victim_way][set] <= 1'b1;
			dirty_q[victim_way][set] <= 1'b0;
			victim_q[set]            <= ~victim_q[set];  // other way goes next
		end else if (clean_en) begin
			dirty_q[victim_way][set] <= 1'b0;
		end else if (wr_hit) begin
			dirty_q[hit_way][set] <= 1'b1;
		end
	end

	// tag and data
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_q[victim_way][set]  <= req_tag;
			data_q[victim_way][set] <= fill_line;
		end else if (wr_hit) begin
			data_q[hit_way][set][sel*`DC_WORD_BITS +: `DC_WORD_BITS] <= proc_req.wdata;
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	a_fill_clean_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(fill_en && clean_en))
		else $error("fill and clean requested together");

	// a line is only filled on a miss, so never resident twice
	a_hit_onehot: assert property (@(posedge clk) disable iff (proc_reset)
		$onehot0(way_hit))
		else $error("address hits in both ways of set %0d", set);

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
// miss FSM; the processor must hold its request while stalled, one miss at a time
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      proc_reset,
	input  proc_req_t proc_req,
	input  logic      hit,
	input  logic      victim_dirty,
	input  line_t     victim_line,
	input  tag_t      victim_tag,
	input  line_t     mem_rdata,
	input  logic      mem_ready,
	output logic      proc_stall,
	output mem_req_t  mem_req,
	output logic      fill_en,
	output line_t     fill_line,
	output logic      clean_en
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic        gap_q;       // memory answered last cycle
	logic        miss;
	set_idx_t    set;
	line_addr_t  req_line;

	assign miss     = (proc_req.read || proc_req.write) && !hit;
	assign set      = proc_req.addr[$bits(word_sel_t) +: $bits(set_idx_t)];
	assign req_line = proc_req.addr[$bits(word_addr_t)-1 -: $bits(line_addr_t)];

	assign fill_line = mem_rdata;  // refill takes the whole line

	// --------------------------------------------------
	// next state and outputs
	// --------------------------------------------------

	always_comb begin
		state_d    = state_q;
		proc_stall = 1'b0;
		mem_req    = '0;
		fill_en    = 1'b0;
		clean_en   = 1'b0;

		unique case (state_q)
			COMPARE: begin
				proc_stall = miss;  // hits go through with no wait
				if (miss) begin
					state_d = victim_dirty ? WRITE_BACK : ALLOCATE;
				end
			end

			WRITE_BACK: begin
				proc_stall    = 1'b1;
				mem_req.write = 1'b1;
				mem_req.addr  = {victim_tag, set};  // victim's own line address
				mem_req.wdata = victim_line;
				if (mem_ready) begin
					clean_en = 1'b1;
					state_d  = ALLOCATE;
				end
			end

			ALLOCATE: begin
				proc_stall   = 1'b1;
				mem_req.read = !gap_q;  // idle one cycle after a write-back
				mem_req.addr = req_line;
				if (mem_ready && !gap_q) begin
					fill_en = 1'b1;
					state_d = COMPARE;  // request replays as a hit
				end
			end

			default: begin
				state_d = COMPARE;
			end
		endcase
	end

	// --------------------------------------------------
	// state registers
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= COMPARE;
			gap_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			gap_q   <= mem_ready;
		end
	end

	// --------------------------------------------------
	// memory handshake checks
	// --------------------------------------------------

	a_mem_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req))
		else $error("memory request changed before ready");

	a_mem_rw_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write))
		else $error("memory read and write together");

	// request drops for one cycle after every ready pulse
	a_mem_gap: assert property (@(posedge clk) disable iff (proc_reset)
		mem_ready |=> !(mem_req.read || mem_req.write))
		else $error("memory request still high after ready");

endmodule

`default_nettype wire

// File: dcache_top.sv
// write-back data cache, 4 sets x 2 ways x 4 words; misses stall the processor
`timescale 1ns/1ps
`default_nettype none

module dcache_top
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      proc_reset,
	input  proc_req_t proc_req,
	input  line_t     mem_rdata,
	input  logic      mem_ready,
	output word_t     proc_rdata,
	output logic      proc_stall,
	output mem_req_t  mem_req
);

	// --------------------------------------------------
	// store to controller
	// --------------------------------------------------

	logic  hit;
	logic  victim_dirty;
	line_t victim_line;
	tag_t  victim_tag;
	logic  fill_en;
	line_t fill_line;
	logic  clean_en;

	dcache_store u_store (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_req     (proc_req),
		.fill_en      (fill_en),
		.fill_line    (fill_line),
		.clean_en     (clean_en),
		.hit          (hit),
		.hit_way      (),             // only used inside the store
		.rdata        (proc_rdata),
		.victim_way   (),
		.victim_dirty (victim_dirty),
		.victim_line  (victim_line),
		.victim_tag   (victim_tag)
	);

	dcache_ctrl u_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_req     (proc_req),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_line  (victim_line),
		.victim_tag   (victim_tag),
		.mem_rdata    (mem_rdata),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.mem_req      (mem_req),
		.fill_en      (fill_en),
		.fill_line    (fill_line),
		.clean_en     (clean_en)
	);

	a_proc_rw_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(proc_req.read && proc_req.write))
		else $error("processor read and write together");

endmodule

`default_nettype wire

// File: tb_slow_mem.sv
// line memory for the testbench; 256 lines by low address bits, ready 1 to 4 cycles, 64 logged writes
`timescale 1ns/1ps
`default_nettype none

module tb_slow_mem
	import dcache_pkg::*;
(
	input  logic     clk,
	input  logic     proc_reset,
	input  mem_req_t mem_req,
	output line_t    mem_rdata,
	output logic     mem_ready
);

	line_t       lines    [256];
	line_addr_t  log_addr [64];   // write log read by the testbench
	line_t       log_data [64];
	int          wr_count;
	int          rd_count;
	logic [31:0] rng;
	logic        busy;
	logic        done_q;          // ready pulse is on this cycle
	int          wait_cnt;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		for (int l = 0; l < 256; l++) begin
			lines[l] = {4{32'(l)}};  // every word holds its line address
		end
		mem_rdata = '0;
		mem_ready = 1'b0;
	end

	// --------------------------------------------------
	// request, random wait, one-cycle ready
	// --------------------------------------------------

	always @(posedge clk) begin
		if (proc_reset) begin
			busy      <= 1'b0;
			done_q    <= 1'b0;
			wait_cnt  <= 0;
			wr_count  <= 0;
			rd_count  <= 0;
			rng       <= 32'h0eed_1800;
			mem_ready <= #2 1'b0;
		end else if (done_q) begin
			busy      <= 1'b0;
			done_q    <= 1'b0;
			mem_ready <= #2 1'b0;
		end else if (!busy && (mem_req.read || mem_req.write)) begin
			rng      <= xorshift32(rng);
			wait_cnt <= xorshift32(rng) % 4 + 1;
			busy     <= 1'b1;
		end else if (busy && wait_cnt > 1) begin
			wait_cnt <= wait_cnt - 1;
		end else if (busy) begin
			done_q    <= 1'b1;
			mem_ready <= #2 1'b1;
			if (mem_req.write) begin
				lines[mem_req.addr[7:0]] <= mem_req.wdata;
				log_addr[wr_count]       <= mem_req.addr;
				log_data[wr_count]       <= mem_req.wdata;
				wr_count                 <= wr_count + 1;
			end else begin
				mem_rdata <= #2 lines[mem_req.addr[7:0]];
				rd_count  <= rd_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_dcache.sv
// replays the vector file against dcache_top; vector addresses must stay below word 1024
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
	import dcache_pkg::*;
();

	localparam int MAX_VEC = 64;

	logic       clk;
	logic       proc_reset;
	proc_req_t  proc_req;
	word_t      proc_rdata;
	logic       proc_stall;
	mem_req_t   mem_req;
	line_t      mem_rdata;
	logic       mem_ready;

	byte        vec_op    [MAX_VEC];
	word_addr_t vec_addr  [MAX_VEC];
	word_t      vec_wdata [MAX_VEC];
	word_t      vec_exp   [MAX_VEC];
	int         vec_mem   [MAX_VEC];  // expected memory transfers
	int         n_vec;
	int         cycles;
	int         limit;
	word_t      shadow    [1024];     // word-level reference memory

	initial clk = 1'b0;
	always #20 clk = ~clk;

	dcache_top UUT (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req)
	);

	tb_slow_mem u_mem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	// --------------------------------------------------
	// reporting
	// --------------------------------------------------

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		if (act !== exp) begin
			abort_run($sformatf("mismatch %s expected %0h actual %0h", name, exp, act));
		end
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		string       text;
		byte         op;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] ex;
		int          mc;
		fd = $fopen("dcache_vectors.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open dcache_vectors.txt");
		end
		n_vec = 0;
		while (!$feof(fd)) begin
			text = "";
			n = $fgets(text, fd);
			n = $sscanf(text, "%c %h %h %h %d", op, a, wd, ex, mc);
			if (n == 5 && n_vec < MAX_VEC) begin  // comment and blank lines fall out here
				vec_op[n_vec]    = op;
				vec_addr[n_vec]  = a[29:0];
				vec_wdata[n_vec] = wd;
				vec_exp[n_vec]   = ex;
				vec_mem[n_vec]   = mc;
				n_vec++;
			end
		end
		$fclose(fd);
	endtask

	// timeout
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			abort_run("timeout: the cache kept the processor stalled too long");
		end
	end

	// --------------------------------------------------
	// vector replay
	// --------------------------------------------------

	initial begin
		int    wr0;
		int    rd0;
		int    l;
		line_t exp_line;
		proc_req   = '0;
		proc_reset = 1'b1;
		cycles     = 0;
		limit      = 0;
		for (int a = 0; a < 1024; a++) begin
			shadow[a] = a >> 2;  // line address in every word
		end
		load_vectors();
		limit = n_vec * 12;
		repeat (3) @(posedge clk);
		#2;
		proc_reset = 1'b0;
		for (int i = 0; i < n_vec; i++) begin
			wr0            = u_mem.wr_count;
			rd0            = u_mem.rd_count;
			proc_req.read  = (vec_op[i] == "R");
			proc_req.write = (vec_op[i] == "W");
			proc_req.addr  = vec_addr[i];
			proc_req.wdata = vec_wdata[i];
			@(negedge clk);
			while (proc_stall) begin  // request held until the miss is served
				if (mem_req.read && mem_req.write) begin
					abort_run("memory read and write requested together");
				end
				if (mem_req.read && vec_mem[i] == 2 && u_mem.wr_count == wr0) begin
					abort_run("refill requested before the dirty line was written back");
				end
				@(negedge clk);
			end
			if (vec_op[i] == "R") begin
				check_value($sformatf("vector %0d against model", i),
					shadow[vec_addr[i][9:0]], vec_exp[i]);
				check_value($sformatf("vector %0d rdata", i), vec_exp[i], proc_rdata);
			end
			check_value($sformatf("vector %0d refills", i), vec_mem[i] > 0,
				u_mem.rd_count - rd0);
			check_value($sformatf("vector %0d write-backs", i), vec_mem[i] == 2,
				u_mem.wr_count - wr0);
			for (int k = wr0; k < u_mem.wr_count; k++) begin
				l        = u_mem.log_addr[k];
				exp_line = {shadow[l*4+3], shadow[l*4+2], shadow[l*4+1], shadow[l*4]};
				check_value($sformatf("vector %0d write-back line %0h", i, l),
					exp_line, u_mem.log_data[k]);
			end
			if (vec_op[i] == "W") begin
				shadow[vec_addr[i][9:0]] = vec_wdata[i];
			end
			@(posedge clk);  // accepted here
			#2;
		end
		proc_req = '0;
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
dcache_pkg.sv
dcache_store.sv
dcache_ctrl.sv
dcache_top.sv
tb_slow_mem.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_store.sv
      - dcache_ctrl.sv
      - dcache_top.sv
  - target: simulation
    files:
      - tb_slow_mem.sv
      - tb_dcache.sv

// File: dcache_vectors.txt
# op word_addr wdata expected_rdata (hex) then memory transfers: 0 hit, 1 refill, 2 write-back and refill
# expected_rdata is ignored for W; untouched memory words hold their own line address
R 00000005 00000000 00000001 1
R 00000006 00000000 00000001 0
W 00000006 cafe0006 00000000 0
R 00000006 00000000 cafe0006 0
R 00000015 00000000 00000005 1
W 00000017 beef0017 00000000 0
R 00000004 00000000 00000001 0
R 00000014 00000000 00000005 0
R 00000006 00000000 cafe0006 0
R 00000017 00000000 beef0017 0
R 00000024 00000000 00000009 2
R 00000006 00000000 cafe0006 2
R 00000017 00000000 beef0017 1
W 00000035 12340035 00000000 1
R 00000035 00000000 12340035 0
W 00000100 a5a50100 00000000 1
R 00000102 00000000 00000040 0
R 00000100 00000000 a5a50100 0
R 000003fc 00000000 000000ff 1
R 00000024 00000000 00000009 1
R 00000034 00000000 0000000d 0
R 00000014 00000000 00000005 2
